// File: logic/alu_unit.sv
// registered arithmetic unit
`timescale 1ns/1ps
`default_nettype none

module alu_unit
   import eng_pkg::*, conf_pkg::*;
(
   input  logic      rst,
   input  logic      clk,
   input  logic      run_reg,
   input  data_bus_t bus,
   input  alu_conf_t conf,
   output word_t     result
);

   word_t op_a;
   word_t op_b;
   word_t res_d;

   assign op_a = bus[conf.sel_a];
   assign op_b = bus[conf.sel_b];

   // wraps modulo 2^16
   always_comb begin
      unique case (conf.op)
         OP_ADD:  res_d = op_a + op_b;
         OP_SUB:  res_d = op_a - op_b;
         OP_AND:  res_d = op_a & op_b;
         OP_XOR:  res_d = op_a ^ op_b;
         default: res_d = '0;
      endcase
   end

   // cleared again at the start of every run
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         result <= '0;
      end else if (run_reg) begin
         result <= '0;
      end else begin
         result <= res_d;
      end
   end

endmodule

`default_nettype wire

// File: logic/conf_pkg.sv
// unit configuration layout
`default_nettype none

package conf_pkg;

   import eng_pkg::*;

   // one memory port address generator
   typedef struct packed {
      logic                en;
      logic                wr;
      bus_sel_t            sel;
      mem_addr_t           start;
      mem_addr_t           incr;
      logic [MEM_ADDR_W:0] count;
      logic [1:0]          delay;
   } port_conf_t;

   typedef enum logic [1:0] {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_AND = 2'd2,
      OP_XOR = 2'd3
   } alu_op_t;

   typedef struct packed {
      alu_op_t  op;
      bus_sel_t sel_a;
      bus_sel_t sel_b;
   } alu_conf_t;

   // msb first, memory ports then alus
   typedef struct packed {
      port_conf_t mem0a;
      port_conf_t mem0b;
      port_conf_t mem1a;
      port_conf_t mem1b;
      alu_conf_t  alu0;
      alu_conf_t  alu1;
   } conf_bus_t;

endpackage

`default_nettype wire

// File: logic/data_eng.sv
// reconfigurable data engine
`timescale 1ns/1ps
`default_nettype none

module data_eng
   import eng_pkg::*, conf_pkg::*;
(
   input  logic                  rst,
   input  logic                  clk,

   // control interface
   input  logic                  ctr_valid,
   input  logic                  ctr_we,
   input  logic [MEM_ADDR_W+1:0] ctr_addr,
   input  word_t                 ctr_data_in,
   output word_t                 ctr_data_out,

   // data interface
   input  logic                  data_valid,
   input  logic                  data_we,
   input  logic [MEM_ADDR_W:0]   data_addr,
   input  word_t                 data_data_in,
   output word_t                 data_data_out,

   input  conf_bus_t             config_bus
);

   mem_host_if ctr_if  [N_MEM] ();
   mem_host_if data_if [N_MEM] ();

   logic               ctrl_access;
   logic               run;
   logic               run_reg;
   logic               all_done;
   logic               ctr_sel_q;
   logic               data_sel_q;
   logic [2*N_MEM-1:0] mem_done;
   word_t              ctr_rdata  [N_MEM];
   word_t              data_rdata [N_MEM];
   conf_bus_t          shadow;
   port_conf_t         conf_a [N_MEM];
   port_conf_t         conf_b [N_MEM];
   alu_conf_t          conf_alu [N_ALU];
   word_t              mem_out_a [N_MEM];
   word_t              mem_out_b [N_MEM];
   word_t              alu_out [N_ALU];
   data_bus_t          bus;

   // top address bit picks the control register
   assign ctrl_access = ctr_valid & ctr_addr[MEM_ADDR_W+1];
   assign run         = ctrl_access & ctr_we & ctr_data_in[0];
   assign all_done    = &mem_done;

   // host strobes into each memory
   for (genvar i = 0; i < N_MEM; i++) begin : gen_host
      assign ctr_if[i].valid = ctr_valid & ~ctr_addr[MEM_ADDR_W+1]
                               & (ctr_addr[MEM_ADDR_W] == 1'(i));
      assign ctr_if[i].we    = ctr_we;
      assign ctr_if[i].addr  = ctr_addr[MEM_ADDR_W-1:0];
      assign ctr_if[i].wdata = ctr_data_in;
      assign ctr_rdata[i]    = ctr_if[i].rdata;

      assign data_if[i].valid = data_valid & (data_addr[MEM_ADDR_W] == 1'(i));
      assign data_if[i].we    = data_we;
      assign data_if[i].addr  = data_addr[MEM_ADDR_W-1:0];
      assign data_if[i].wdata = data_data_in;
      assign data_rdata[i]    = data_if[i].rdata;
   end

   // memory selects, kept one cycle to match the registered read data
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         ctr_sel_q  <= 1'b0;
         data_sel_q <= 1'b0;
      end else begin
         ctr_sel_q  <= ctr_addr[MEM_ADDR_W];
         data_sel_q <= data_addr[MEM_ADDR_W];
      end
   end

   // status read is combinational
   assign ctr_data_out  = ctrl_access ? word_t'(all_done) : ctr_rdata[ctr_sel_q];
   assign data_data_out = data_rdata[data_sel_q];

   // run pulse and config snapshot
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         run_reg <= 1'b0;
         shadow  <= '0;
      end else begin
         run_reg <= run;
         if (run) begin
            shadow <= config_bus;
         end
      end
   end

   assign conf_a[0]   = shadow.mem0a;
   assign conf_b[0]   = shadow.mem0b;
   assign conf_a[1]   = shadow.mem1a;
   assign conf_b[1]   = shadow.mem1b;
   assign conf_alu[0] = shadow.alu0;
   assign conf_alu[1] = shadow.alu1;

   always_comb begin
      bus[BUS_ZERO]  = '0;
      bus[BUS_ONE]   = word_t'(1);
      bus[BUS_MEM0A] = mem_out_a[0];
      bus[BUS_MEM0B] = mem_out_b[0];
      bus[BUS_MEM1A] = mem_out_a[1];
      bus[BUS_MEM1B] = mem_out_b[1];
      bus[BUS_ALU0]  = alu_out[0];
      bus[BUS_ALU1]  = alu_out[1];
   end

   for (genvar i = 0; i < N_MEM; i++) begin : gen_mem
      mem_unit u_mem (
         .rst       (rst),
         .clk       (clk),
         .run_reg   (run_reg),
         .bus       (bus),
         .conf_a    (conf_a[i]),
         .conf_b    (conf_b[i]),
         .ctr_host  (ctr_if[i]),
         .data_host (data_if[i]),
         .out_a     (mem_out_a[i]),
         .out_b     (mem_out_b[i]),
         .done_a    (mem_done[2*i]),
         .done_b    (mem_done[2*i+1])
      );
   end

   for (genvar i = 0; i < N_ALU; i++) begin : gen_alu
      alu_unit u_alu (
         .rst     (rst),
         .clk     (clk),
         .run_reg (run_reg),
         .bus     (bus),
         .conf    (conf_alu[i]),
         .result  (alu_out[i])
      );
   end

   // a new run only once every port has finished
   a_run_when_idle : assert property (
      @(posedge rst) disable iff (clk)
      run |-> all_done
   ) else $error("run issued while a memory port is busy");

endmodule

`default_nettype wire

// File: logic/eng_pkg.sv
// engine sizes and data bus types
`default_nettype none

package eng_pkg;

   // data path and unit counts
   localparam int DATA_W     = 16;
   localparam int N_MEM      = 2;
   localparam int MEM_DEPTH  = 16;
   localparam int MEM_ADDR_W = 4;
   localparam int N_ALU      = 2;
   localparam int N_BUS      = 8;

   typedef logic [DATA_W-1:0]        word_t;
   typedef logic [MEM_ADDR_W-1:0]    mem_addr_t;
   typedef logic [$clog2(N_BUS)-1:0] bus_sel_t;

   // data bus entries, constants first, then memory ports, then alus
   localparam bus_sel_t BUS_ZERO  = 3'd0;
   localparam bus_sel_t BUS_ONE   = 3'd1;
   localparam bus_sel_t BUS_MEM0A = 3'd2;
   localparam bus_sel_t BUS_MEM0B = 3'd3;
   localparam bus_sel_t BUS_MEM1A = 3'd4;
   localparam bus_sel_t BUS_MEM1B = 3'd5;
   localparam bus_sel_t BUS_ALU0  = 3'd6;
   localparam bus_sel_t BUS_ALU1  = 3'd7;

   // one word per bus entry
   typedef word_t data_bus_t [N_BUS];

endpackage

`default_nettype wire

// File: logic/mem_host_if.sv
// host access to one memory
`timescale 1ns/1ps
`default_nettype none

interface mem_host_if
   import eng_pkg::*;
();

   // one-cycle strobe, never refused
   logic      valid;
   logic      we;
   mem_addr_t addr;
   word_t     wdata;

   // registered, word addressed on the previous cycle
   word_t     rdata;

   modport host (
      output valid, we, addr, wdata,
      input  rdata
   );

   modport mem (
      input  valid, we, addr, wdata,
      output rdata
   );

endinterface

`default_nettype wire

// File: logic/mem_unit.sv
// dual-port memory with address generators
`timescale 1ns/1ps
`default_nettype none

module mem_unit
   import eng_pkg::*, conf_pkg::*;
(
   input  logic       rst,
   input  logic       clk,
   input  logic       run_reg,
   input  data_bus_t  bus,
   input  port_conf_t conf_a,
   input  port_conf_t conf_b,
   mem_host_if.mem    ctr_host,
   mem_host_if.mem    data_host,
   output word_t      out_a,
   output word_t      out_b,
   output logic       done_a,
   output logic       done_b
);

   word_t      mem [MEM_DEPTH];

   // port a at index 0, port b at index 1
   port_conf_t conf [2];
   logic [1:0] busy;
   logic [1:0] act;
   logic [1:0] start;
   logic [1:0] done;
   mem_addr_t  addr [2];
   word_t      out [2];

   assign conf[0] = conf_a;
   assign conf[1] = conf_b;

   for (genvar g = 0; g < 2; g++) begin : gen_port
      logic                busy_q;
      logic [1:0]          wait_q;
      logic [MEM_ADDR_W:0] left_q;
      mem_addr_t           addr_q;
      word_t               out_q;

      // zero count means nothing to do
      assign start[g] = run_reg & conf[g].en & (conf[g].count != '0);
      assign act[g]   = busy_q & (wait_q == 2'd0);
      assign busy[g]  = busy_q;
      assign addr[g]  = addr_q;
      assign out[g]   = out_q;
      assign done[g]  = ~(busy_q | start[g]);

      always_ff @(posedge rst or posedge clk) begin
         if (clk) begin
            busy_q <= 1'b0;
            wait_q <= 2'd0;
            left_q <= '0;
            addr_q <= '0;
         end else if (run_reg) begin
            busy_q <= start[g];
            wait_q <= conf[g].delay;
            left_q <= conf[g].count;
            addr_q <= conf[g].start;
         end else if (busy_q) begin
            if (wait_q != 2'd0) begin
               wait_q <= wait_q - 2'd1;
            end else begin
               // address wraps within the 16 words
               addr_q <= addr_q + conf[g].incr;
               left_q <= left_q - 1'b1;
               if (left_q == 1'b1) begin
                  busy_q <= 1'b0;
               end
            end
         end
      end

      // read data reaches the bus one cycle after the access
      always_ff @(posedge rst or posedge clk) begin
         if (clk) begin
            out_q <= '0;
         end else if (act[g] && !conf[g].wr) begin
            out_q <= mem[addr_q];
         end
      end
   end

   // host writes, then generator writes
   always_ff @(posedge rst) begin
      if (ctr_host.valid && ctr_host.we) begin
         mem[ctr_host.addr] <= ctr_host.wdata;
      end
      if (data_host.valid && data_host.we) begin
         mem[data_host.addr] <= data_host.wdata;
      end
      for (int p = 0; p < 2; p++) begin
         if (act[p] && conf[p].wr) begin
            mem[addr[p]] <= bus[conf[p].sel];
         end
      end
   end

   always_ff @(posedge rst) begin
      ctr_host.rdata  <= mem[ctr_host.addr];
      data_host.rdata <= mem[data_host.addr];
   end

   assign out_a  = out[0];
   assign out_b  = out[1];
   assign done_a = done[0];
   assign done_b = done[1];

   // host may only write while both generators are idle
   a_no_host_write_busy : assert property (
      @(posedge rst) disable iff (clk)
      ((ctr_host.valid && ctr_host.we) || (data_host.valid && data_host.we))
         |-> (busy == 2'b00)
   ) else $error("host write while a memory port is busy");

endmodule

`default_nettype wire

// File: tb/eng_cases.txt
// per case: config word, mem0 and mem1 loaded (words 0 to 15), then mem0 and mem1 expected
// config word: mem0a mem0b mem1a mem1b ports (20 bits each), alu0 alu1 (8 bits each)
000000000000000000000000
0000 1111 2222 3333 4444 5555 6666 7777 8888 9999 aaaa bbbb cccc dddd eeee ffff
ffff eeee dddd cccc bbbb aaaa 9999 8888 7777 6666 5555 4444 3333 2222 1111 0000
0000 1111 2222 3333 4444 5555 6666 7777 8888 9999 aaaa bbbb cccc dddd eeee ffff
ffff eeee dddd cccc bbbb aaaa 9999 8888 7777 6666 5555 4444 3333 2222 1111 0000
812940000000000d51950000
1000 1011 1022 1033 1044 1055 1066 1077 1088 1099 10aa 10bb 10cc 10dd 10ee 10ff
2000 2011 2022 2033 2044 2055 2066 2077 2088 2099 20aa 20bb 20cc 20dd 20ee 20ff
1000 1011 1022 1033 1044 1055 1066 1077 1088 1099 10aa 10bb 10cc 10dd 10ee 10ff
10cc 2011 2022 1011 2044 2055 1066 2077 2088 2099 1022 20bb 20cc 1077 20ee 20ff
800a0f40a2800a0fc0a21462
8000 9001 a002 b003 c004 d005 e006 f007 0008 1009 200a 300b 400c 500d 600e 700f
7ff0 8100 8210 8320 8430 8540 8650 8760 8870 8980 8a90 8ba0 8cb0 8dc0 8ed0 8fe0
8000 9001 a002 b003 c004 d005 e006 f007 fff0 1101 2212 3323 4434 5545 6656 7767
7ff0 8100 8210 8320 8430 8540 8650 8760 fff0 f0ff e20e d31d c42c b53b a64a 9759
800a0f40a2800a0fc0a294d4
0000 1111 2222 3333 4444 5555 6666 7777 8888 9999 aaaa bbbb cccc dddd eeee ffff
3c5a 3d5b 3e5c 3f5d 405e 415f 4260 4361 4462 4563 4664 4765 4866 4967 4a68 4b69
0000 1111 2222 3333 4444 5555 6666 7777 0000 1111 2200 3311 4044 4155 4260 4361
3c5a 3d5b 3e5c 3f5d 405e 415f 4260 4361 3c5a 2c4a 1c7e 0c6e 041a 140a 2406 3416
86918f211a00000c0a901100
0fff 1fff 2fff 3fff 4fff 5fff 6fff 7fff 8fff 9fff afff bfff cfff dfff efff ffff
a500 a511 a522 a533 a544 a555 a566 a577 a588 a599 a5aa a5bb a5cc a5dd a5ee a5ff
0fff 1fff 2fff 3fff e000 5fff 0000 7fff 2000 9fff 4000 bfff 6000 dfff 8000 ffff
0000 0000 a522 a533 a544 a555 0000 a577 a588 a599 a5aa 0000 a5cc a5dd a5ee a5ff

// File: tb/tb_data_eng.sv
// data engine testbench
`timescale 1ns/1ps
`default_nettype none

module tb_data_eng
   import eng_pkg::*, conf_pkg::*;
();

   localparam int N_CASES     = 5;
   localparam int N_WORDS     = 32;
   // config word, loaded words, expected words
   localparam int CASE_LEN    = 1 + 2 * N_WORDS;
   localparam int CYCLE_LIMIT = 200 * N_CASES + 100;

   // rst is the clock and clk the reset, as named on the DUT
   logic        rst;
   logic        clk;
   logic        ctr_valid;
   logic        ctr_we;
   logic [5:0]  ctr_addr;
   word_t       ctr_data_in;
   word_t       ctr_data_out;
   logic        data_valid;
   logic        data_we;
   logic [4:0]  data_addr;
   word_t       data_data_in;
   word_t       data_data_out;
   conf_bus_t   config_bus;
   logic [95:0] cases_mem [N_CASES*CASE_LEN];
   int          cycles;

   data_eng DUT (
      .rst           (rst),
      .clk           (clk),
      .ctr_valid     (ctr_valid),
      .ctr_we        (ctr_we),
      .ctr_addr      (ctr_addr),
      .ctr_data_in   (ctr_data_in),
      .ctr_data_out  (ctr_data_out),
      .data_valid    (data_valid),
      .data_we       (data_we),
      .data_addr     (data_addr),
      .data_data_in  (data_data_in),
      .data_data_out (data_data_out),
      .config_bus    (config_bus)
   );

   initial begin
      rst = 1'b0;
      forever #20 rst = ~rst;
   end

   // run limit, counted in clock cycles
   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge rst);
         cycles++;
      end
      $display("timeout waiting for done after %0d cycles", cycles);
      $display("** FAIL **");
      $fatal(1);
   end

   // inputs move 2 ns after the rising edge
   task automatic next_cycle();
      @(posedge rst);
      #2;
   endtask

   task automatic check_word(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         $display("Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   task automatic check_done(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("Error at %0t ns: %s read %b, expected %b", $time, what, got, exp);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   // even words through the control path, odd words through the data path
   task automatic write_word(input int idx, input word_t value);
      if (idx % 2 == 0) begin
         ctr_valid   = 1'b1;
         ctr_we      = 1'b1;
         ctr_addr    = {1'b0, 5'(idx)};
         ctr_data_in = value;
      end else begin
         data_valid   = 1'b1;
         data_we      = 1'b1;
         data_addr    = 5'(idx);
         data_data_in = value;
      end
      next_cycle();
      ctr_valid  = 1'b0;
      ctr_we     = 1'b0;
      data_valid = 1'b0;
      data_we    = 1'b0;
   endtask

   // reads each word through the path that did not write it, one strobe per cycle
   task automatic read_all(input int exp_base, input string what);
      word_t got;
      for (int i = 0; i <= N_WORDS; i++) begin
         ctr_valid  = 1'b0;
         data_valid = 1'b0;
         if (i < N_WORDS) begin
            if (i % 2 == 0) begin
               data_valid = 1'b1;
               data_addr  = 5'(i);
            end else begin
               ctr_valid = 1'b1;
               ctr_addr  = {1'b0, 5'(i)};
            end
         end
         if (i > 0) begin
            @(negedge rst);
            got = ((i - 1) % 2 == 0) ? data_data_out : ctr_data_out;
            check_word(got, word_t'(cases_mem[exp_base+i-1]),
                       $sformatf("%s word %0d", what, i - 1));
         end
         next_cycle();
      end
      ctr_valid  = 1'b0;
      data_valid = 1'b0;
   endtask

   // status is combinational, sampled mid cycle
   task automatic read_status(output logic done);
      ctr_valid = 1'b1;
      ctr_we    = 1'b0;
      ctr_addr  = 6'h20;
      @(negedge rst);
      done = ctr_data_out[0];
      next_cycle();
      ctr_valid = 1'b0;
   endtask

   task automatic issue_run();
      ctr_valid   = 1'b1;
      ctr_we      = 1'b1;
      ctr_addr    = 6'h20;
      ctr_data_in = 16'h0001;
      next_cycle();
      ctr_valid = 1'b0;
      ctr_we    = 1'b0;
   endtask

   task automatic run_case(input int c);
      int        base;
      conf_bus_t cfg;
      logic      any_en;
      logic      done;
      base   = c * CASE_LEN;
      cfg    = conf_bus_t'(cases_mem[base]);
      any_en = cfg.mem0a.en | cfg.mem0b.en | cfg.mem1a.en | cfg.mem1b.en;
      for (int j = 0; j < N_WORDS; j++) begin
         write_word(j, word_t'(cases_mem[base+1+j]));
      end
      read_all(base + 1, $sformatf("case %0d load", c));
      config_bus = cfg;
      issue_run();
      // the shadow copy must hide this change
      config_bus = conf_bus_t'(~cfg);
      read_status(done);
      check_done(done, ~any_en, $sformatf("case %0d status after run", c));
      while (!done) begin
         read_status(done);
      end
      read_all(base + 1 + N_WORDS, $sformatf("case %0d result", c));
   endtask

   initial begin
      logic done;
      clk          = 1'b1;
      ctr_valid    = 1'b0;
      ctr_we       = 1'b0;
      ctr_addr     = '0;
      ctr_data_in  = '0;
      data_valid   = 1'b0;
      data_we      = 1'b0;
      data_addr    = '0;
      data_data_in = '0;
      config_bus   = '0;
      $readmemh("tb/eng_cases.txt", cases_mem);
      if ($isunknown(cases_mem[N_CASES*CASE_LEN-1])) begin
         $display("case file tb/eng_cases.txt is missing or too short");
         $display("** FAIL **");
         $fatal(1);
      end
      repeat (3) @(posedge rst);
      #2;
      clk = 1'b0;
      read_status(done);
      check_done(done, 1'b1, "status after reset");
      for (int c = 0; c < N_CASES; c++) begin
         run_case(c);
      end
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
logic/eng_pkg.sv
logic/conf_pkg.sv
logic/mem_host_if.sv
logic/mem_unit.sv
logic/alu_unit.sv
logic/data_eng.sv
tb/tb_data_eng.sv
